// ==== design/core_cfg_pkg.sv ====
package core_cfg_pkg;

   // machine widths
   localparam int XLEN   = 64;
   localparam int ADDR_W = 39; // sv39 sized virtual address

   typedef logic [XLEN-1:0]   xlen_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // x0..x31
   typedef logic [4:0] reg_idx_t;

   // load/store sequencer
   typedef enum logic {
      LSU_IDLE, // waiting for a load or store
      LSU_BUSY  // request on the bus until ready
   } lsu_state_e;

endpackage

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

   // major opcodes, instruction bits [6:0]
   typedef enum logic [6:0] {
      OPC_LUI       = 7'b0110111,
      OPC_AUIPC     = 7'b0010111,
      OPC_JAL       = 7'b1101111,
      OPC_JALR      = 7'b1100111,
      OPC_BRANCH    = 7'b1100011,
      OPC_LOAD      = 7'b0000011,
      OPC_STORE     = 7'b0100011,
      OPC_OP_IMM    = 7'b0010011,
      OPC_OP_IMM_32 = 7'b0011011, // addiw slliw srliw sraiw
      OPC_OP        = 7'b0110011,
      OPC_OP_32     = 7'b0111011  // addw subw sllw srlw sraw
   } opcode_e;

   // alu operations, word form is a separate flag
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_SLT,
      ALU_SLTU,
      ALU_PASS_IMM, // lui
      ALU_ADD_PC,   // auipc
      ALU_LINK      // jal/jalr return address
   } alu_op_e;

   // branch funct3, 010 and 011 reserved
   typedef enum logic [2:0] {
      BR_EQ  = 3'b000,
      BR_NE  = 3'b001,
      BR_LT  = 3'b100,
      BR_GE  = 3'b101,
      BR_LTU = 3'b110,
      BR_GEU = 3'b111
   } branch_f3_e;

   // load/store funct3, also the bus size code
   typedef enum logic [2:0] {
      LS_B  = 3'b000,
      LS_H  = 3'b001,
      LS_W  = 3'b010,
      LS_D  = 3'b011,
      LS_BU = 3'b100,
      LS_HU = 3'b101,
      LS_WU = 3'b110
   } ls_size_e;

   localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

// ==== design/dec_if.sv ====
`timescale 1ns/100ps

interface dec_if;
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;

   reg_idx_t   rd;
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   xlen_t      imm;       // already sign extended
   alu_op_e    alu_op;
   logic       word_op;   // 32-bit form, result sign extended from bit 31
   logic       use_imm;   // operand b is imm, not rs2
   logic       writes_rd; // false for x0, branch, store
   logic       is_branch;
   logic       is_jal;
   logic       is_jalr;
   logic       is_load;
   logic       is_store;
   logic [2:0] funct3;    // branch condition or load/store size

   // decoder side
   modport dec (output rd, rs1, rs2, imm, alu_op, word_op, use_imm, writes_rd,
                output is_branch, is_jal, is_jalr, is_load, is_store, funct3);

   // read side for alu, regs, pc and lsu
   modport usr (input rd, rs1, rs2, imm, alu_op, word_op, use_imm, writes_rd,
                input is_branch, is_jal, is_jalr, is_load, is_store, funct3);

endinterface

// ==== design/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit (
   input  logic [31:0] instr_i,
   dec_if.dec          dec
);
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;

   opcode_e     opc_raw;
   logic        known;
   logic [31:0] ir;      // word actually decoded
   opcode_e     opc;
   logic        reg_form; // op and op_32 take operand b from rs2
   xlen_t       imm_i;
   xlen_t       imm_s;
   xlen_t       imm_b;
   xlen_t       imm_u;
   xlen_t       imm_j;

   assign opc_raw = opcode_e'(instr_i[6:0]);

   // filter words we do not execute
   always_comb begin
      case (opc_raw)
         OPC_LUI, OPC_AUIPC, OPC_JAL: known = 1'b1;
         OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: known = 1'b1;
         OPC_JALR:   known = (instr_i[14:12] == 3'b000);
         OPC_BRANCH: known = (instr_i[14:13] != 2'b01); // 010/011 reserved
         OPC_LOAD:   known = (instr_i[14:12] != 3'b111);
         OPC_STORE:  known = ~instr_i[14];               // sb sh sw sd only
         default:    known = 1'b0;
      endcase
   end

   assign ir  = known ? instr_i : NOP_INSTR; // unknown words retire as addi x0
   assign opc = opcode_e'(ir[6:0]);
   assign reg_form = (opc == OPC_OP) || (opc == OPC_OP_32);

   // immediates
   assign imm_i = {{52{ir[31]}}, ir[31:20]};
   assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
   assign imm_b = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
   assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
   assign imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

   assign dec.rd     = ir[11:7];
   assign dec.rs1    = ir[19:15];
   assign dec.rs2    = ir[24:20];
   assign dec.funct3 = ir[14:12];

   assign dec.word_op   = (opc == OPC_OP_IMM_32) || (opc == OPC_OP_32);
   assign dec.use_imm   = ~reg_form;
   assign dec.is_branch = (opc == OPC_BRANCH);
   assign dec.is_jal    = (opc == OPC_JAL);
   assign dec.is_jalr   = (opc == OPC_JALR);
   assign dec.is_load   = (opc == OPC_LOAD);
   assign dec.is_store  = (opc == OPC_STORE);
   assign dec.writes_rd = (ir[11:7] != 5'd0) && (opc != OPC_BRANCH) && (opc != OPC_STORE);

   always_comb begin
      case (opc)
         OPC_STORE:          dec.imm = imm_s;
         OPC_BRANCH:         dec.imm = imm_b;
         OPC_LUI, OPC_AUIPC: dec.imm = imm_u;
         OPC_JAL:            dec.imm = imm_j;
         default:            dec.imm = imm_i; // op_imm, load, jalr
      endcase
   end

   // alu op from opcode, funct3, funct7 bit 5
   always_comb begin
      case (opc)
         OPC_LUI:           dec.alu_op = ALU_PASS_IMM;
         OPC_AUIPC:         dec.alu_op = ALU_ADD_PC;
         OPC_JAL, OPC_JALR: dec.alu_op = ALU_LINK;
         OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: begin
            case (ir[14:12])
               3'b000:  dec.alu_op = (reg_form && ir[30]) ? ALU_SUB : ALU_ADD; // no subi
               3'b001:  dec.alu_op = ALU_SLL;
               3'b010:  dec.alu_op = ALU_SLT;
               3'b011:  dec.alu_op = ALU_SLTU;
               3'b100:  dec.alu_op = ALU_XOR;
               3'b101:  dec.alu_op = ir[30] ? ALU_SRA : ALU_SRL;
               3'b110:  dec.alu_op = ALU_OR;
               default: dec.alu_op = ALU_AND;
            endcase
         end
         default: dec.alu_op = ALU_ADD; // load/store address and branch compare done elsewhere
      endcase
   end

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
   dec_if.usr                  dec,
   input  core_cfg_pkg::addr_t pc_i,
   input  core_cfg_pkg::xlen_t rs1_val_i,
   input  core_cfg_pkg::xlen_t rs2_val_i,
   output core_cfg_pkg::xlen_t result_o
);
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;

   xlen_t      op_a;
   xlen_t      op_b;
   xlen_t      sh_a;  // shift source
   xlen_t      pc_x;  // pc widened to xlen
   xlen_t      res;   // full width result before word fixup
   logic [5:0] shamt;

   assign op_a  = rs1_val_i;
   assign op_b  = dec.use_imm ? dec.imm : rs2_val_i;
   assign shamt = dec.word_op ? {1'b0, op_b[4:0]} : op_b[5:0]; // 5 bits for word forms
   assign pc_x  = {{(XLEN-ADDR_W){1'b0}}, pc_i};

   // word right shifts only see the low word
   always_comb begin
      if (!dec.word_op) begin
         sh_a = op_a;
      end else if (dec.alu_op == ALU_SRA) begin
         sh_a = {{32{op_a[31]}}, op_a[31:0]};
      end else begin
         sh_a = {32'b0, op_a[31:0]};
      end
   end

   always_comb begin
      case (dec.alu_op)
         ALU_ADD:      res = op_a + op_b;
         ALU_SUB:      res = op_a - op_b;
         ALU_XOR:      res = op_a ^ op_b;
         ALU_OR:       res = op_a | op_b;
         ALU_AND:      res = op_a & op_b;
         ALU_SLL:      res = sh_a << shamt;
         ALU_SRL:      res = sh_a >> shamt;
         ALU_SRA:      res = $signed(sh_a) >>> shamt;
         ALU_SLT:      res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         ALU_SLTU:     res = {{(XLEN-1){1'b0}}, op_a < op_b};
         ALU_PASS_IMM: res = dec.imm;          // lui
         ALU_ADD_PC:   res = pc_x + dec.imm;   // auipc
         ALU_LINK:     res = pc_x + xlen_t'(4); // return address
         default:      res = '0;
      endcase
   end

   // word forms sign extend from bit 31
   assign result_o = dec.word_op ? {{32{res[31]}}, res[31:0]} : res;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
   input  logic                clk,
   input  logic                reset,
   dec_if.usr                  dec,
   input  logic                stall_i,
   input  core_cfg_pkg::xlen_t alu_result_i,
   input  logic                load_valid_i,
   input  core_cfg_pkg::xlen_t load_data_i,
   output core_cfg_pkg::xlen_t rs1_val_o,
   output core_cfg_pkg::xlen_t rs2_val_o
);
   import core_cfg_pkg::*;

   xlen_t regs [0:31];
   logic  we;
   xlen_t wdata;

   // loads write at the bus transfer, everything else on a free retire
   assign we    = load_valid_i || (!stall_i && dec.writes_rd && !dec.is_load);
   assign wdata = load_valid_i ? load_data_i : alu_result_i;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (dec.rd != 5'd0)) begin // x0 stays zero
         regs[dec.rd] <= wdata;
      end
   end

   // two combinational read ports
   assign rs1_val_o = regs[dec.rs1];
   assign rs2_val_o = regs[dec.rs2];

endmodule

// ==== design/pc_unit.sv ====
`timescale 1ns/100ps

module pc_unit #(
   parameter core_cfg_pkg::addr_t RESET_VECTOR = '0
) (
   input  logic                clk,
   input  logic                reset,
   dec_if.usr                  dec,
   input  logic                stall_i,
   input  core_cfg_pkg::xlen_t rs1_val_i,
   input  core_cfg_pkg::xlen_t rs2_val_i,
   output core_cfg_pkg::addr_t pc_o
);
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;

   logic  taken;    // branch condition holds
   xlen_t jalr_sum; // rs1 + imm
   addr_t pc_next;

   // six branch conditions
   always_comb begin
      case (branch_f3_e'(dec.funct3))
         BR_EQ:   taken = (rs1_val_i == rs2_val_i);
         BR_NE:   taken = (rs1_val_i != rs2_val_i);
         BR_LT:   taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
         BR_GE:   taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
         BR_LTU:  taken = (rs1_val_i < rs2_val_i);
         BR_GEU:  taken = (rs1_val_i >= rs2_val_i);
         default: taken = 1'b0;
      endcase
   end

   assign jalr_sum = rs1_val_i + dec.imm;

   always_comb begin
      if (dec.is_jalr) begin
         pc_next = {jalr_sum[ADDR_W-1:1], 1'b0}; // bit 0 cleared
      end else if (dec.is_jal || (dec.is_branch && taken)) begin
         pc_next = pc_o + dec.imm[ADDR_W-1:0];   // pc relative
      end else begin
         pc_next = pc_o + addr_t'(4);
      end
   end

   // pc holds while a load/store waits on the bus
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc_o <= RESET_VECTOR;
      end else if (!stall_i) begin
         pc_o <= pc_next;
      end
   end

endmodule

// ==== design/lsu_ctrl.sv ====
`timescale 1ns/100ps

module lsu_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   dec_if.usr                   dec,
   input  core_cfg_pkg::xlen_t  rs1_val_i,
   input  core_cfg_pkg::xlen_t  rs2_val_i,
   output logic                 stall_o,
   output logic                 load_valid_o,
   output core_cfg_pkg::xlen_t  load_data_o,
   output logic                 bus_valid_o,
   output logic                 bus_write_o,
   output core_cfg_pkg::addr_t  bus_addr_o,
   output core_cfg_pkg::xlen_t  bus_wdata_o,
   output rv_isa_pkg::ls_size_e bus_size_o,
   input  logic                 bus_ready_i,
   input  core_cfg_pkg::xlen_t  bus_rdata_i
);
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;

   lsu_state_e state;
   logic       mem_op;   // load or store presented
   logic       start;    // leaving idle this cycle
   ls_size_e   size_d;
   xlen_t      eff_addr;
   xlen_t      wdata_d;  // store data, low bytes only

   assign mem_op   = dec.is_load || dec.is_store;
   assign start    = (state == LSU_IDLE) && mem_op;
   assign size_d   = ls_size_e'(dec.funct3);
   assign eff_addr = rs1_val_i + dec.imm;

   always_comb begin
      case (size_d)
         LS_B:    wdata_d = {56'b0, rs2_val_i[7:0]};
         LS_H:    wdata_d = {48'b0, rs2_val_i[15:0]};
         LS_W:    wdata_d = {32'b0, rs2_val_i[31:0]};
         default: wdata_d = rs2_val_i;
      endcase
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state       <= LSU_IDLE;
         bus_write_o <= 1'b0;
      end else if (start) begin
         state       <= LSU_BUSY;
         bus_write_o <= dec.is_store;
      end else if ((state == LSU_BUSY) && bus_ready_i) begin // transfer edge
         state       <= LSU_IDLE;
         bus_write_o <= 1'b0;
      end
   end

   // request payload, stable for the whole busy phase
   always_ff @(posedge clk) begin
      if (start) begin
         bus_addr_o  <= eff_addr[ADDR_W-1:0];
         bus_size_o  <= size_d;
         bus_wdata_o <= wdata_d;
      end
   end

   assign bus_valid_o  = (state == LSU_BUSY);
   assign stall_o      = start || ((state == LSU_BUSY) && !bus_ready_i);
   assign load_valid_o = (state == LSU_BUSY) && bus_ready_i && !bus_write_o;

   // extend read data by the latched size
   always_comb begin
      case (bus_size_o)
         LS_B:    load_data_o = {{56{bus_rdata_i[7]}}, bus_rdata_i[7:0]};
         LS_H:    load_data_o = {{48{bus_rdata_i[15]}}, bus_rdata_i[15:0]};
         LS_W:    load_data_o = {{32{bus_rdata_i[31]}}, bus_rdata_i[31:0]};
         LS_BU:   load_data_o = {56'b0, bus_rdata_i[7:0]};
         LS_HU:   load_data_o = {48'b0, bus_rdata_i[15:0]};
         LS_WU:   load_data_o = {32'b0, bus_rdata_i[31:0]};
         default: load_data_o = bus_rdata_i; // ld
      endcase
   end

endmodule

// ==== design/rv64_core.sv ====
`timescale 1ns/100ps

module rv64_core #(
   parameter core_cfg_pkg::addr_t RESET_VECTOR = '0
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [31:0]          instr_i,     // returned for pc_o, same cycle
   output core_cfg_pkg::addr_t  pc_o,
   output logic                 bus_valid_o,
   output logic                 bus_write_o,
   output core_cfg_pkg::addr_t  bus_addr_o,
   output core_cfg_pkg::xlen_t  bus_wdata_o,
   output rv_isa_pkg::ls_size_e bus_size_o,
   input  logic                 bus_ready_i,
   input  core_cfg_pkg::xlen_t  bus_rdata_i  // valid in the transfer cycle only
);
   import core_cfg_pkg::*;

   xlen_t rs1_val;
   xlen_t rs2_val;
   xlen_t alu_result;
   xlen_t load_data;
   logic  stall;      // load/store not finished
   logic  load_valid; // load data returns this cycle

   dec_if dec_bus ();

   decode_unit u_decode (
      .instr_i (instr_i),
      .dec     (dec_bus)
   );

   reg_file u_regs (
      .clk          (clk),
      .reset        (reset),
      .dec          (dec_bus),
      .stall_i      (stall),
      .alu_result_i (alu_result),
      .load_valid_i (load_valid),
      .load_data_i  (load_data),
      .rs1_val_o    (rs1_val),
      .rs2_val_o    (rs2_val)
   );

   int_alu u_alu (
      .dec       (dec_bus),
      .pc_i      (pc_o),
      .rs1_val_i (rs1_val),
      .rs2_val_i (rs2_val),
      .result_o  (alu_result)
   );

   pc_unit #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_pc (
      .clk       (clk),
      .reset     (reset),
      .dec       (dec_bus),
      .stall_i   (stall),
      .rs1_val_i (rs1_val),
      .rs2_val_i (rs2_val),
      .pc_o      (pc_o)
   );

   lsu_ctrl u_lsu (
      .clk          (clk),
      .reset        (reset),
      .dec          (dec_bus),
      .rs1_val_i    (rs1_val),
      .rs2_val_i    (rs2_val),
      .stall_o      (stall),
      .load_valid_o (load_valid),
      .load_data_o  (load_data),
      .bus_valid_o  (bus_valid_o),
      .bus_write_o  (bus_write_o),
      .bus_addr_o   (bus_addr_o),
      .bus_wdata_o  (bus_wdata_o),
      .bus_size_o   (bus_size_o),
      .bus_ready_i  (bus_ready_i),
      .bus_rdata_i  (bus_rdata_i)
   );

endmodule

// ==== testbench/tb_rv64_core.sv ====
`timescale 1ns/100ps

module tb_rv64_core;
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;

   localparam addr_t RESET_VEC  = 39'h100;
   localparam int    IMEM_WORDS = 256;  // bytes 0x000..0x3ff
   localparam int    DMEM_WORDS = 256;  // bytes 0x000..0x7ff

   logic     clk;
   logic     reset;
   logic [31:0] instr;
   addr_t    pc;
   logic     bus_valid;
   logic     bus_write;
   addr_t    bus_addr;
   xlen_t    bus_wdata;
   ls_size_e bus_size;
   logic     bus_ready;
   xlen_t    bus_rdata;

   logic [31:0] imem [0:IMEM_WORDS-1];
   xlen_t       dmem [0:DMEM_WORDS-1];
   addr_t       exp_addr [$]; // expected writes in program order
   ls_size_e    exp_size [$];
   xlen_t       exp_data [$];
   addr_t       prog_lo;
   addr_t       prog_hi;
   int          n_records;
   logic        loaded;
   logic        reached_end;
   logic        store_seen;   // first store presented
   integer      seed;

   rv64_core #(.RESET_VECTOR (RESET_VEC)) uut (
      .clk         (clk),
      .reset       (reset),
      .instr_i     (instr),
      .pc_o        (pc),
      .bus_valid_o (bus_valid),
      .bus_write_o (bus_write),
      .bus_addr_o  (bus_addr),
      .bus_wdata_o (bus_wdata),
      .bus_size_o  (bus_size),
      .bus_ready_i (bus_ready),
      .bus_rdata_i (bus_rdata)
   );

   assign instr = imem[pc[9:2]]; // combinational fetch

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "run stopped");
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         stop_run($sformatf("error %0t %s expected %h actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
      if (act !== exp) begin
         stop_run($sformatf("error %0t %s expected %h actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_size(input string name, input ls_size_e exp, input ls_size_e act);
      if (act !== exp) stop_run($sformatf("error %0t %s expected %0d actual %0d", $time, name,
                                          int'(exp), int'(act)));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_run($sformatf("error %0t %s expected %b actual %b", $time, name, exp, act));
      end
   endtask

   // reads P, M and W records and skips # lines
   task automatic load_trace();
      integer      fd;
      integer      r;
      string       tag;
      string       rest;
      logic [63:0] a;
      logic [63:0] d;
      logic [31:0] w [4];
      int          s;
      fd = $fopen("testbench/core_trace.txt", "r");
      if (fd == 0) stop_run("cannot open testbench/core_trace.txt");
      while (!$feof(fd)) begin
         tag = "";
         r = $fscanf(fd, "%s", tag);
         if (r != 1) break;
         if (tag == "#") begin
            r = $fgets(rest, fd);
         end else if (tag == "P") begin
            r = $fscanf(fd, "%h %h %h %h %h", a, w[0], w[1], w[2], w[3]);
            for (int k = 0; k < 4; k++) begin
               imem[a[9:2] + 8'(k)] = w[k];
            end
            if (a[ADDR_W-1:0] < prog_lo) prog_lo = a[ADDR_W-1:0];
            if (a[ADDR_W-1:0] + 39'd12 > prog_hi) prog_hi = a[ADDR_W-1:0] + 39'd12;
         end else if (tag == "M") begin
            r = $fscanf(fd, "%h %h", a, d);
            dmem[a[10:3]] = d;
         end else if (tag == "W") begin
            r = $fscanf(fd, "%h %d %h", a, s, d);
            exp_addr.push_back(a[ADDR_W-1:0]);
            exp_size.push_back(ls_size_e'(s[2:0]));
            exp_data.push_back(d);
         end else begin
            stop_run($sformatf("unknown record type %s in the trace file", tag));
         end
         n_records++;
      end
      $fclose(fd);
   endtask

   // data memory with 0..3 wait cycles before ready
   initial begin
      int       delay;
      int       waited;
      int       idx;
      int       off;
      int       nbytes;
      addr_t    a_hold;
      xlen_t    w_hold;
      ls_size_e s_hold;
      logic     wr_hold;
      delay  = 0;
      waited = -1;
      forever begin
         @(posedge clk);
         #1;
         if (bus_ready) begin // transfer happened at this edge
            bus_ready = 1'b0;
            bus_rdata = '0;
            waited    = -1;
         end else if (bus_valid) begin
            if (waited < 0) begin
               a_hold  = bus_addr;
               w_hold  = bus_wdata;
               s_hold  = bus_size;
               wr_hold = bus_write;
               delay   = $random(seed) & 3;
               waited  = 0;
            end else begin // request must hold while stalled
               check_addr("bus_addr_o", a_hold, bus_addr);
               check_word("bus_wdata_o", w_hold, bus_wdata);
               check_size("bus_size_o", s_hold, bus_size);
               check_flag("bus_write_o", wr_hold, bus_write);
               waited++;
            end
            if (waited == delay) begin
               if (bus_addr > 39'h7ff) stop_run("data access outside the data memory");
               idx    = int'(bus_addr[10:3]);
               off    = int'(bus_addr[2:0]);
               nbytes = 1 << bus_size[1:0];
               if (off + nbytes > 8) stop_run("access crosses a doubleword boundary");
               if (bus_write) begin
                  if (exp_addr.size() == 0) stop_run("bus write beyond the expected list");
                  check_addr("bus_addr_o", exp_addr.pop_front(), bus_addr);
                  check_size("bus_size_o", exp_size.pop_front(), bus_size);
                  check_word("bus_wdata_o", exp_data.pop_front(), bus_wdata);
                  for (int b = 0; b < nbytes; b++) begin
                     dmem[idx][8*(off+b) +: 8] = bus_wdata[8*b +: 8];
                  end
               end else begin
                  bus_rdata = dmem[idx] >> (8 * off); // addressed bytes to the bottom
               end
               bus_ready = 1'b1;
            end
         end
      end
   end

   // watchdog scaled by trace length
   initial begin
      int limit;
      wait (loaded);
      limit = 20 * n_records + 200;
      repeat (limit) @(posedge clk);
      stop_run("watchdog expired, the program never reached its end loop");
   end

   initial begin
      seed        = 32'h5c2c;
      reset       = 1'b0;
      bus_ready   = 1'b0;
      bus_rdata   = '0;
      loaded      = 1'b0;
      reached_end = 1'b0;
      store_seen  = 1'b0;
      n_records   = 0;
      prog_lo     = '1;
      prog_hi     = '0;
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = {25'(i), 7'h7f}; // unknown opcode retires as nop
      end
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = {32'(i) * 32'h9e37_79b1, 32'(i) ^ 32'h5a5a_0000};
      end
      load_trace();
      loaded = 1'b1;
      repeat (8) @(posedge clk);
      #1 reset = 1'b1;
      check_addr("pc_o", RESET_VEC, pc);
      check_flag("bus_valid_o", 1'b0, bus_valid);
      while (!reached_end) begin
         @(posedge clk);
         #2;
         if (pc < prog_lo || pc > prog_hi) stop_run("pc left the loaded program");
         if (!store_seen) begin // no bus request before the first store
            check_flag("bus_valid_o", 1'b0, bus_valid);
            store_seen = (instr[6:0] == OPC_STORE);
         end
         if (instr == 32'h0000_006f) reached_end = 1'b1; // jal x0, 0
      end
      if (exp_addr.size() != 0) begin
         stop_run($sformatf("end loop reached with %0d expected writes missing",
                            exp_addr.size()));
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

// ==== compile.f ====
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/dec_if.sv
design/decode_unit.sv
design/int_alu.sv
design/reg_file.sv
design/pc_unit.sv
design/lsu_ctrl.sv
design/rv64_core.sv
testbench/tb_rv64_core.sv

// ==== run_sim.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --timing -j 0 -f compile.f --top-module tb_rv64_core -o sim_rv64 \
   && ./obj_dir/sim_rv64 > sim.log 2>&1 \
   || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// ==== testbench/core_trace.txt ====
# P byte_addr word0 word1 word2 word3 : four program words from byte_addr
# M byte_addr data : preloaded data doubleword
# W byte_addr size data : expected bus write in order, size is the funct3 code
M 400 f0e1d2c3b4a59687
P 100 40000093 10008113 ffb00193 12345237
P 110 67820213 004182b3 00513023 40320333
P 120 0041c3b3 00613423 00713823 02421413
P 130 4011d493 00813c23 02913023 0032151b
P 140 4045559b 4041863b 0041d69b 02a13423
P 150 02b13823 02c13c23 04d13023 00008703
P 160 0000d783 0000a803 04e13423 04f12823
P 170 05011c23 06310023 00000463 06313423
P 180 00001463 06413823 0001c463 06413c23
P 190 008008ef 06413c23 09113023 1a900967
P 1a0 06413c23 06413c23 09213423 00001997
P 1b0 09313823 0000006f 0000006f 0000006f
W 500 3 0000000012345673
W 508 3 000000001234567d
W 510 3 ffffffffedcba983
W 518 3 2345678000000000
W 520 3 fffffffffffffffd
W 528 3 ffffffff91a2b3c0
W 530 3 fffffffff91a2b3c
W 538 3 ffffffffedcba983
W 540 3 000000000fffffff
W 548 3 ffffffffffffff87
W 550 2 0000000000009687
W 558 1 0000000000009687
W 560 0 00000000000000fb
W 570 3 0000000012345678
W 580 3 0000000000000194
W 588 3 00000000000001a0
W 590 3 00000000000011ac
